// ==== hw/mcu_ctrl_pkg.sv ====
// shared widths, register offsets and the register select type
// for the always-on control block

package mcu_ctrl_pkg;

  localparam int DATA_W = 32;
  localparam int ADDR_W = 8;

  // soc control
  localparam logic [ADDR_W-1:0] EXIT_VALUE_OFS = 8'h00;
  localparam logic [ADDR_W-1:0] EXIT_VALID_OFS = 8'h04;
  localparam logic [ADDR_W-1:0] STRAPS_OFS     = 8'h08;

  // gpio bank
  localparam logic [ADDR_W-1:0] GPIO_OUT_OFS         = 8'h10;
  localparam logic [ADDR_W-1:0] GPIO_OE_OFS          = 8'h14;
  localparam logic [ADDR_W-1:0] GPIO_IN_OFS          = 8'h18;
  localparam logic [ADDR_W-1:0] GPIO_INTR_EN_OFS     = 8'h1C;
  localparam logic [ADDR_W-1:0] GPIO_INTR_STATUS_OFS = 8'h20;

  // fast interrupt collector
  localparam logic [ADDR_W-1:0] IRQ_MASK_OFS    = 8'h30;
  localparam logic [ADDR_W-1:0] IRQ_PENDING_OFS = 8'h34;

  // register selected by the current access
  typedef enum logic [3:0] {
    SEL_NONE,
    SEL_EXIT_VALUE,
    SEL_EXIT_VALID,
    SEL_STRAPS,
    SEL_GPIO_OUT,
    SEL_GPIO_OE,
    SEL_GPIO_IN,
    SEL_GPIO_INTR_EN,
    SEL_GPIO_INTR_STATUS,
    SEL_IRQ_MASK,
    SEL_IRQ_PENDING
  } reg_sel_e;

endpackage

// ==== hw/ctrl_bus_if.sv ====
// decoded register access bus
// driven by the apb decoder, read by the register units

`timescale 1ns/10ps

interface ctrl_bus_if;

  // single-cycle strobes, one per apb transfer
  logic wr_en;
  logic rd_en;

  mcu_ctrl_pkg::reg_sel_e sel;
  logic [mcu_ctrl_pkg::DATA_W-1:0] wdata;

  modport decoder (
    output wr_en,
    output rd_en,
    output sel,
    output wdata
  );

  modport unit (
    input wr_en,
    input rd_en,
    input sel,
    input wdata
  );

endinterface

// ==== hw/apb_decode.sv ====
// apb transfer tracking and address decode
// issues one register strobe in the first access cycle

`timescale 1ns/10ps

module apb_decode (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic [mcu_ctrl_pkg::ADDR_W-1:0]   paddr_i,
  input  logic                              psel_i,
  input  logic                              penable_i,
  input  logic                              pwrite_i,
  input  logic [mcu_ctrl_pkg::DATA_W-1:0]   pwdata_i,
  ctrl_bus_if.decoder                       bus
);

  logic access_seen;
  logic first_access;

  // high from the end of the first access cycle until the transfer ends
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      access_seen <= 1'b0;
    end else begin
      access_seen <= psel_i & penable_i;
    end
  end

  assign first_access = psel_i & penable_i & ~access_seen;

  assign bus.wr_en = first_access & pwrite_i;
  assign bus.rd_en = first_access & ~pwrite_i;
  assign bus.wdata = pwdata_i;

  always_comb begin
    case (paddr_i)
      mcu_ctrl_pkg::EXIT_VALUE_OFS:       bus.sel = mcu_ctrl_pkg::SEL_EXIT_VALUE;
      mcu_ctrl_pkg::EXIT_VALID_OFS:       bus.sel = mcu_ctrl_pkg::SEL_EXIT_VALID;
      mcu_ctrl_pkg::STRAPS_OFS:           bus.sel = mcu_ctrl_pkg::SEL_STRAPS;
      mcu_ctrl_pkg::GPIO_OUT_OFS:         bus.sel = mcu_ctrl_pkg::SEL_GPIO_OUT;
      mcu_ctrl_pkg::GPIO_OE_OFS:          bus.sel = mcu_ctrl_pkg::SEL_GPIO_OE;
      mcu_ctrl_pkg::GPIO_IN_OFS:          bus.sel = mcu_ctrl_pkg::SEL_GPIO_IN;
      mcu_ctrl_pkg::GPIO_INTR_EN_OFS:     bus.sel = mcu_ctrl_pkg::SEL_GPIO_INTR_EN;
      mcu_ctrl_pkg::GPIO_INTR_STATUS_OFS: bus.sel = mcu_ctrl_pkg::SEL_GPIO_INTR_STATUS;
      mcu_ctrl_pkg::IRQ_MASK_OFS:         bus.sel = mcu_ctrl_pkg::SEL_IRQ_MASK;
      mcu_ctrl_pkg::IRQ_PENDING_OFS:      bus.sel = mcu_ctrl_pkg::SEL_IRQ_PENDING;
      // anything else is answered with an error
      default:                            bus.sel = mcu_ctrl_pkg::SEL_NONE;
    endcase
  end

endmodule

// ==== hw/soc_ctrl_regs.sv ====
// exit value and sticky exit valid registers
// read-only view of the boot straps

`timescale 1ns/10ps

module soc_ctrl_regs (
  input  logic                             clk_i,
  input  logic                             rst_i,
  ctrl_bus_if.unit                         bus,
  input  logic                             boot_select_i,
  input  logic                             execute_from_flash_i,
  output logic [mcu_ctrl_pkg::DATA_W-1:0]  exit_value_o,
  output logic                             exit_valid_o,
  output logic [mcu_ctrl_pkg::DATA_W-1:0]  rdata_o
);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_value_o <= '0;
      exit_valid_o <= 1'b0;
    end else if (bus.wr_en) begin
      if (bus.sel == mcu_ctrl_pkg::SEL_EXIT_VALUE) begin
        exit_value_o <= bus.wdata;
      end
      // sticks until reset
      if (bus.sel == mcu_ctrl_pkg::SEL_EXIT_VALID && bus.wdata[0]) begin
        exit_valid_o <= 1'b1;
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    case (bus.sel)
      mcu_ctrl_pkg::SEL_EXIT_VALUE: rdata_o = exit_value_o;
      mcu_ctrl_pkg::SEL_EXIT_VALID: rdata_o[0] = exit_valid_o;
      mcu_ctrl_pkg::SEL_STRAPS: begin
        rdata_o[0] = boot_select_i;
        rdata_o[1] = execute_from_flash_i;
      end
      default: rdata_o = '0;
    endcase
  end

endmodule

// ==== hw/gpio_bank.sv ====
// gpio output and output enable registers, input synchronizer
// and per-pin rising edge interrupts with w1c status

`timescale 1ns/10ps

module gpio_bank #(
  parameter int NUM_GPIO = 8
) (
  input  logic                             clk_i,
  input  logic                             rst_i,
  ctrl_bus_if.unit                         bus,
  input  logic [NUM_GPIO-1:0]              gpio_i,
  output logic [NUM_GPIO-1:0]              gpio_o,
  output logic [NUM_GPIO-1:0]              gpio_oe_o,
  output logic [NUM_GPIO-1:0]              gpio_intr_o,
  output logic [mcu_ctrl_pkg::DATA_W-1:0]  rdata_o
);

  localparam int PAD_W = mcu_ctrl_pkg::DATA_W - NUM_GPIO;

  logic [NUM_GPIO-1:0] sync_q1;
  logic [NUM_GPIO-1:0] sync_q2;
  logic [NUM_GPIO-1:0] in_prev;
  logic [NUM_GPIO-1:0] intr_en;
  logic [NUM_GPIO-1:0] status;
  logic [NUM_GPIO-1:0] rise;
  logic [NUM_GPIO-1:0] status_set;
  logic [NUM_GPIO-1:0] status_clr;
  logic [NUM_GPIO-1:0] wr_bits;

  assign wr_bits = bus.wdata[NUM_GPIO-1:0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gpio_o    <= '0;
      gpio_oe_o <= '0;
      intr_en   <= '0;
    end else if (bus.wr_en) begin
      case (bus.sel)
        mcu_ctrl_pkg::SEL_GPIO_OUT:     gpio_o    <= wr_bits;
        mcu_ctrl_pkg::SEL_GPIO_OE:      gpio_oe_o <= wr_bits;
        mcu_ctrl_pkg::SEL_GPIO_INTR_EN: intr_en   <= wr_bits;
        default: ;
      endcase
    end
  end

  // two-flop synchronizer plus one more stage for edge detect
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
      in_prev <= '0;
    end else begin
      sync_q1 <= gpio_i;
      sync_q2 <= sync_q1;
      in_prev <= sync_q2;
    end
  end

  assign rise       = sync_q2 & ~in_prev;
  assign status_set = rise & intr_en;
  assign status_clr = (bus.wr_en && bus.sel == mcu_ctrl_pkg::SEL_GPIO_INTR_STATUS) ?
                      wr_bits : '0;

  // a new edge wins over a clear in the same cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      status <= '0;
    end else begin
      status <= (status & ~status_clr) | status_set;
    end
  end

  assign gpio_intr_o = status;

  always_comb begin
    case (bus.sel)
      mcu_ctrl_pkg::SEL_GPIO_OUT:         rdata_o = {{PAD_W{1'b0}}, gpio_o};
      mcu_ctrl_pkg::SEL_GPIO_OE:          rdata_o = {{PAD_W{1'b0}}, gpio_oe_o};
      mcu_ctrl_pkg::SEL_GPIO_IN:          rdata_o = {{PAD_W{1'b0}}, sync_q2};
      mcu_ctrl_pkg::SEL_GPIO_INTR_EN:     rdata_o = {{PAD_W{1'b0}}, intr_en};
      mcu_ctrl_pkg::SEL_GPIO_INTR_STATUS: rdata_o = {{PAD_W{1'b0}}, status};
      default:                            rdata_o = '0;
    endcase
  end

endmodule

// ==== hw/irq_collect.sv ====
// fast interrupt vector assembly
// gpio summary in bit 0, external lines above, gated by a mask

`timescale 1ns/10ps

module irq_collect #(
  parameter int NUM_GPIO = 8,
  parameter int NEXT_INT = 4
) (
  input  logic                             clk_i,
  input  logic                             rst_i,
  ctrl_bus_if.unit                         bus,
  input  logic [NUM_GPIO-1:0]              gpio_intr_i,
  input  logic [NEXT_INT-1:0]              intr_ext_i,
  output logic [NEXT_INT:0]                fast_intr_o,
  output logic [mcu_ctrl_pkg::DATA_W-1:0]  rdata_o
);

  localparam int PAD_W = mcu_ctrl_pkg::DATA_W - NEXT_INT - 1;

  logic [NEXT_INT:0] raw_vec;
  logic [NEXT_INT:0] mask;

  assign raw_vec = {intr_ext_i, |gpio_intr_i};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mask <= '0;
    end else if (bus.wr_en && bus.sel == mcu_ctrl_pkg::SEL_IRQ_MASK) begin
      mask <= bus.wdata[NEXT_INT:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fast_intr_o <= '0;
    end else begin
      fast_intr_o <= raw_vec & mask;
    end
  end

  // pending shows the registered vector
  always_comb begin
    case (bus.sel)
      mcu_ctrl_pkg::SEL_IRQ_MASK:    rdata_o = {{PAD_W{1'b0}}, mask};
      mcu_ctrl_pkg::SEL_IRQ_PENDING: rdata_o = {{PAD_W{1'b0}}, fast_intr_o};
      default:                       rdata_o = '0;
    endcase
  end

endmodule

// ==== hw/read_result.sv ====
// read data selection and apb response
// one fixed wait state, ready pulses for a single cycle

`timescale 1ns/10ps

module read_result (
  input  logic                             clk_i,
  input  logic                             rst_i,
  ctrl_bus_if.unit                         bus,
  input  logic [mcu_ctrl_pkg::DATA_W-1:0]  soc_rdata_i,
  input  logic [mcu_ctrl_pkg::DATA_W-1:0]  gpio_rdata_i,
  input  logic [mcu_ctrl_pkg::DATA_W-1:0]  irq_rdata_i,
  output logic [mcu_ctrl_pkg::DATA_W-1:0]  prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o
);

  logic [mcu_ctrl_pkg::DATA_W-1:0] sel_rdata;

  always_comb begin
    case (bus.sel)
      mcu_ctrl_pkg::SEL_EXIT_VALUE,
      mcu_ctrl_pkg::SEL_EXIT_VALID,
      mcu_ctrl_pkg::SEL_STRAPS:           sel_rdata = soc_rdata_i;
      mcu_ctrl_pkg::SEL_GPIO_OUT,
      mcu_ctrl_pkg::SEL_GPIO_OE,
      mcu_ctrl_pkg::SEL_GPIO_IN,
      mcu_ctrl_pkg::SEL_GPIO_INTR_EN,
      mcu_ctrl_pkg::SEL_GPIO_INTR_STATUS: sel_rdata = gpio_rdata_i;
      mcu_ctrl_pkg::SEL_IRQ_MASK,
      mcu_ctrl_pkg::SEL_IRQ_PENDING:      sel_rdata = irq_rdata_i;
      default:                            sel_rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      prdata_o  <= '0;
      pready_o  <= 1'b0;
      pslverr_o <= 1'b0;
    end else begin
      pready_o <= bus.wr_en | bus.rd_en;
      if (bus.wr_en || bus.rd_en) begin
        // writes return zero
        prdata_o  <= bus.rd_en ? sel_rdata : '0;
        pslverr_o <= (bus.sel == mcu_ctrl_pkg::SEL_NONE);
      end
    end
  end

endmodule

// ==== hw/mcu_ctrl_top.sv ====
// always-on control block top level
// apb slave port, soc control, gpio bank and fast interrupt collector

`timescale 1ns/10ps

module mcu_ctrl_top #(
  parameter int NUM_GPIO = 8,
  parameter int NEXT_INT = 4
) (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  logic [mcu_ctrl_pkg::ADDR_W-1:0]  paddr_i,
  input  logic                             psel_i,
  input  logic                             penable_i,
  input  logic                             pwrite_i,
  input  logic [mcu_ctrl_pkg::DATA_W-1:0]  pwdata_i,
  output logic [mcu_ctrl_pkg::DATA_W-1:0]  prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o,
  input  logic                             boot_select_i,
  input  logic                             execute_from_flash_i,
  output logic                             exit_valid_o,
  output logic [mcu_ctrl_pkg::DATA_W-1:0]  exit_value_o,
  input  logic [NUM_GPIO-1:0]              gpio_i,
  output logic [NUM_GPIO-1:0]              gpio_o,
  output logic [NUM_GPIO-1:0]              gpio_oe_o,
  input  logic [NEXT_INT-1:0]              intr_ext_i,
  output logic [NEXT_INT:0]                fast_intr_o
);

  ctrl_bus_if bus ();

  logic [mcu_ctrl_pkg::DATA_W-1:0] soc_rdata;
  logic [mcu_ctrl_pkg::DATA_W-1:0] gpio_rdata;
  logic [mcu_ctrl_pkg::DATA_W-1:0] irq_rdata;
  logic [NUM_GPIO-1:0]             gpio_intr;

  apb_decode apb_decode_i (
    .clk_i, .rst_i, .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
    .bus(bus.decoder)
  );

  soc_ctrl_regs soc_ctrl_regs_i (
    .clk_i, .rst_i, .bus(bus.unit),
    .boot_select_i, .execute_from_flash_i,
    .exit_value_o, .exit_valid_o,
    .rdata_o(soc_rdata)
  );

  gpio_bank #(.NUM_GPIO(NUM_GPIO)) gpio_bank_i (
    .clk_i, .rst_i, .bus(bus.unit),
    .gpio_i, .gpio_o, .gpio_oe_o,
    .gpio_intr_o(gpio_intr),
    .rdata_o(gpio_rdata)
  );

  irq_collect #(.NUM_GPIO(NUM_GPIO), .NEXT_INT(NEXT_INT)) irq_collect_i (
    .clk_i, .rst_i, .bus(bus.unit),
    .gpio_intr_i(gpio_intr), .intr_ext_i,
    .fast_intr_o,
    .rdata_o(irq_rdata)
  );

  read_result read_result_i (
    .clk_i, .rst_i, .bus(bus.unit),
    .soc_rdata_i(soc_rdata), .gpio_rdata_i(gpio_rdata), .irq_rdata_i(irq_rdata),
    .prdata_o, .pready_o, .pslverr_o
  );

endmodule

// ==== test/tb_mcu_ctrl_tasks.svh ====
// lfsr, register reference model and compare tasks
// plus apb and pin driver tasks for the control block testbench

localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

// galois form, shifts right
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  if (state[0]) begin
    return (state >> 1) ^ LFSR_TAPS;
  end
  return state >> 1;
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] random_bits(input int n);
  logic [31:0] value;
  value = '0;
  for (int i = 0; i < n; i++) begin
    value[i] = lfsr_state[0];
    lfsr_state = lfsr_next(lfsr_state);
  end
  return value;
endfunction

function automatic logic [NEXT_INT:0] expected_fast();
  return exp_mask & {intr_ext_i, |exp_status};
endfunction

function automatic logic [DW-1:0] expected_read(input logic [AW-1:0] addr, output logic err);
  logic [DW-1:0] data;
  data = '0;
  err = 1'b0;
  case (addr)
    mcu_ctrl_pkg::EXIT_VALUE_OFS:       data = exp_exit_value;
    mcu_ctrl_pkg::EXIT_VALID_OFS:       data[0] = exp_exit_valid;
    mcu_ctrl_pkg::STRAPS_OFS:           data[1:0] = {execute_from_flash_i, boot_select_i};
    mcu_ctrl_pkg::GPIO_OUT_OFS:         data[NUM_GPIO-1:0] = exp_gpio_out;
    mcu_ctrl_pkg::GPIO_OE_OFS:          data[NUM_GPIO-1:0] = exp_gpio_oe;
    mcu_ctrl_pkg::GPIO_IN_OFS:          data[NUM_GPIO-1:0] = pin_shadow;
    mcu_ctrl_pkg::GPIO_INTR_EN_OFS:     data[NUM_GPIO-1:0] = exp_intr_en;
    mcu_ctrl_pkg::GPIO_INTR_STATUS_OFS: data[NUM_GPIO-1:0] = exp_status;
    mcu_ctrl_pkg::IRQ_MASK_OFS:         data[NEXT_INT:0] = exp_mask;
    mcu_ctrl_pkg::IRQ_PENDING_OFS:      data[NEXT_INT:0] = expected_fast();
    default:                            err = 1'b1;
  endcase
  return data;
endfunction

// updates the shadow registers, returns the expected error flag
function automatic logic expected_write(input logic [AW-1:0] addr, input logic [DW-1:0] data);
  logic err;
  err = 1'b0;
  case (addr)
    mcu_ctrl_pkg::EXIT_VALUE_OFS:       exp_exit_value = data;
    mcu_ctrl_pkg::EXIT_VALID_OFS:       if (data[0]) exp_exit_valid = 1'b1;
    mcu_ctrl_pkg::GPIO_OUT_OFS:         exp_gpio_out = data[NUM_GPIO-1:0];
    mcu_ctrl_pkg::GPIO_OE_OFS:          exp_gpio_oe = data[NUM_GPIO-1:0];
    mcu_ctrl_pkg::GPIO_INTR_EN_OFS:     exp_intr_en = data[NUM_GPIO-1:0];
    mcu_ctrl_pkg::GPIO_INTR_STATUS_OFS: exp_status = exp_status & ~data[NUM_GPIO-1:0];
    mcu_ctrl_pkg::IRQ_MASK_OFS:         exp_mask = data[NEXT_INT:0];
    mcu_ctrl_pkg::STRAPS_OFS,
    mcu_ctrl_pkg::GPIO_IN_OFS,
    mcu_ctrl_pkg::IRQ_PENDING_OFS:      err = 1'b0;
    default:                            err = 1'b1;
  endcase
  return err;
endfunction

// rising pins with their enable set latch into the status
function automatic void pins_changed(input logic [NUM_GPIO-1:0] value);
  exp_status = exp_status | (value & ~pin_shadow & exp_intr_en);
  pin_shadow = value;
endfunction

task automatic check_data(input logic [DW-1:0] got, input logic [DW-1:0] exp_val,
                          input string what);
  if (got !== exp_val) begin
    abort_run($sformatf("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp_val));
  end
endtask

task automatic check_err(input logic got, input logic exp_val, input string what);
  if (got !== exp_val) begin
    abort_run($sformatf("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp_val));
  end
endtask

task automatic check_irq(input logic [NEXT_INT:0] got, input logic [NEXT_INT:0] exp_val,
                         input string what);
  if (got !== exp_val) begin
    abort_run($sformatf("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp_val));
  end
endtask

task automatic apb_transfer(input logic [AW-1:0] addr, input logic write,
                            input logic [DW-1:0] data);
  int waited;
  logic err;
  logic [DW-1:0] exp_val;
  if (write) begin
    err = expected_write(addr, data);
    exp_val = '0;
  end else begin
    exp_val = expected_read(addr, err);
  end
  exp_data_q.push_back(exp_val);
  exp_err_q.push_back(err);
  @(posedge clk_i);
  paddr_i   <= addr;
  psel_i    <= 1'b1;
  penable_i <= 1'b0;
  pwrite_i  <= write;
  pwdata_i  <= data;
  @(posedge clk_i);
  penable_i <= 1'b1;
  waited = 1;
  @(negedge clk_i);
  while (!pready_o) begin
    @(negedge clk_i);
    waited++;
  end
  if (waited != 2) begin
    abort_run($sformatf("FAILED at %0t: pready_o came %0d cycles after setup, expected 2",
                        $time, waited));
  end
  @(posedge clk_i);
  psel_i    <= 1'b0;
  penable_i <= 1'b0;
endtask

task automatic apb_write(input logic [AW-1:0] addr, input logic [DW-1:0] data);
  apb_transfer(addr, 1'b1, data);
endtask

task automatic apb_read(input logic [AW-1:0] addr);
  apb_transfer(addr, 1'b0, '0);
endtask

task automatic drive_pins(input logic [NUM_GPIO-1:0] value, input int hold);
  @(posedge clk_i);
  gpio_i <= value;
  pins_changed(value);
  repeat (hold) @(posedge clk_i);
endtask

task automatic drive_ext(input logic [NEXT_INT-1:0] value);
  @(posedge clk_i);
  intr_ext_i <= value;
  repeat (2) @(posedge clk_i);
  @(negedge clk_i);
  check_irq(fast_intr_o, expected_fast(), "fast_intr_o after ext change");
endtask

// ==== test/tb_mcu_ctrl.sv ====
// testbench top for the always-on control block
// clock, reset, dut, timeout, response checker and test sequence

`timescale 1ns/10ps

module tb_mcu_ctrl;

  localparam int NUM_GPIO = 8;
  localparam int NEXT_INT = 4;
  localparam int DW = mcu_ctrl_pkg::DATA_W;
  localparam int AW = mcu_ctrl_pkg::ADDR_W;
  // four times 60 transfers of 3 cycles plus settle time
  localparam int TIMEOUT_CYCLES = 4 * (60 * 3 + 200);

  logic                clk_i;
  logic                rst_i;
  logic [AW-1:0]       paddr_i;
  logic                psel_i;
  logic                penable_i;
  logic                pwrite_i;
  logic [DW-1:0]       pwdata_i;
  logic [DW-1:0]       prdata_o;
  logic                pready_o;
  logic                pslverr_o;
  logic                boot_select_i;
  logic                execute_from_flash_i;
  logic                exit_valid_o;
  logic [DW-1:0]       exit_value_o;
  logic [NUM_GPIO-1:0] gpio_i;
  logic [NUM_GPIO-1:0] gpio_o;
  logic [NUM_GPIO-1:0] gpio_oe_o;
  logic [NEXT_INT-1:0] intr_ext_i;
  logic [NEXT_INT:0]   fast_intr_o;

  // reference model state
  logic [DW-1:0]       exp_exit_value;
  logic                exp_exit_valid;
  logic [NUM_GPIO-1:0] exp_gpio_out;
  logic [NUM_GPIO-1:0] exp_gpio_oe;
  logic [NUM_GPIO-1:0] exp_intr_en;
  logic [NUM_GPIO-1:0] exp_status;
  logic [NUM_GPIO-1:0] pin_shadow;
  logic [NEXT_INT:0]   exp_mask;

  logic [31:0]         lfsr_state;
  logic [DW-1:0]       exp_data_q[$];
  logic                exp_err_q[$];
  logic [AW-1:0]       mapped_ofs[10];
  int                  cycle_count;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  `include "tb_mcu_ctrl_tasks.svh"

  mcu_ctrl_top #(.NUM_GPIO(NUM_GPIO), .NEXT_INT(NEXT_INT)) dut_i (
    .clk_i, .rst_i, .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .boot_select_i, .execute_from_flash_i, .exit_valid_o, .exit_value_o,
    .gpio_i, .gpio_o, .gpio_oe_o, .intr_ext_i, .fast_intr_o
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin
    cycle_count = 0;
  end

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  // every apb response against the model
  always @(negedge clk_i) begin
    if (!rst_i && pready_o) begin
      if (exp_data_q.size() == 0) begin
        abort_run("pready_o went high with no transfer in progress");
      end else begin
        check_data(prdata_o, exp_data_q.pop_front(), "prdata_o");
        check_err(pslverr_o, exp_err_q.pop_front(), "pslverr_o");
      end
    end
  end

  initial begin
    logic [DW-1:0] value;
    rst_i <= 1'b1;
    paddr_i <= '0;
    psel_i <= 1'b0;
    penable_i <= 1'b0;
    pwrite_i <= 1'b0;
    pwdata_i <= '0;
    boot_select_i <= 1'b1;
    execute_from_flash_i <= 1'b0;
    gpio_i <= '0;
    intr_ext_i <= '0;
    lfsr_state = 32'd47;
    exp_exit_value = '0;
    exp_exit_valid = 1'b0;
    exp_gpio_out = '0;
    exp_gpio_oe = '0;
    exp_intr_en = '0;
    exp_status = '0;
    pin_shadow = '0;
    exp_mask = '0;
    mapped_ofs = '{mcu_ctrl_pkg::EXIT_VALUE_OFS, mcu_ctrl_pkg::EXIT_VALID_OFS,
                   mcu_ctrl_pkg::STRAPS_OFS, mcu_ctrl_pkg::GPIO_OUT_OFS,
                   mcu_ctrl_pkg::GPIO_OE_OFS, mcu_ctrl_pkg::GPIO_IN_OFS,
                   mcu_ctrl_pkg::GPIO_INTR_EN_OFS, mcu_ctrl_pkg::GPIO_INTR_STATUS_OFS,
                   mcu_ctrl_pkg::IRQ_MASK_OFS, mcu_ctrl_pkg::IRQ_PENDING_OFS};
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;

    // reset values
    @(negedge clk_i);
    check_err(exit_valid_o, 1'b0, "exit_valid_o after reset");
    check_data(DW'(gpio_oe_o), '0, "gpio_oe_o after reset");
    check_irq(fast_intr_o, '0, "fast_intr_o after reset");
    for (int i = 0; i < 10; i++) begin
      apb_read(mapped_ofs[i]);
    end

    // soc control
    value = random_bits(32);
    apb_write(mcu_ctrl_pkg::EXIT_VALUE_OFS, value);
    check_data(exit_value_o, value, "exit_value_o");
    apb_read(mcu_ctrl_pkg::EXIT_VALUE_OFS);
    apb_write(mcu_ctrl_pkg::EXIT_VALID_OFS, 32'd1);
    check_err(exit_valid_o, 1'b1, "exit_valid_o after set");
    apb_write(mcu_ctrl_pkg::EXIT_VALID_OFS, 32'd0);
    check_err(exit_valid_o, 1'b1, "exit_valid_o after writing zero");
    apb_read(mcu_ctrl_pkg::EXIT_VALID_OFS);

    // gpio output, enable and input
    value = random_bits(NUM_GPIO);
    apb_write(mcu_ctrl_pkg::GPIO_OUT_OFS, value);
    check_data(DW'(gpio_o), value, "gpio_o");
    value = random_bits(NUM_GPIO);
    apb_write(mcu_ctrl_pkg::GPIO_OE_OFS, value);
    check_data(DW'(gpio_oe_o), value, "gpio_oe_o");
    apb_read(mcu_ctrl_pkg::GPIO_OUT_OFS);
    apb_read(mcu_ctrl_pkg::GPIO_OE_OFS);
    drive_pins(NUM_GPIO'(random_bits(NUM_GPIO)), 3);
    apb_read(mcu_ctrl_pkg::GPIO_IN_OFS);

    // edge interrupts on a random set of pins
    apb_write(mcu_ctrl_pkg::GPIO_INTR_EN_OFS, random_bits(NUM_GPIO));
    apb_read(mcu_ctrl_pkg::GPIO_INTR_EN_OFS);
    drive_pins('0, 4);
    drive_pins('1, 4);
    apb_read(mcu_ctrl_pkg::GPIO_INTR_STATUS_OFS);
    apb_write(mcu_ctrl_pkg::GPIO_INTR_STATUS_OFS, random_bits(NUM_GPIO));
    apb_read(mcu_ctrl_pkg::GPIO_INTR_STATUS_OFS);

    // fast vector under random mask, status and ext lines
    apb_write(mcu_ctrl_pkg::GPIO_INTR_EN_OFS, '1);
    for (int i = 0; i < 8; i++) begin
      drive_pins(NUM_GPIO'(random_bits(NUM_GPIO)), 4);
      if (random_bits(1) != 0) begin
        apb_write(mcu_ctrl_pkg::GPIO_INTR_STATUS_OFS, random_bits(NUM_GPIO));
      end
      apb_write(mcu_ctrl_pkg::IRQ_MASK_OFS, random_bits(NEXT_INT + 1));
      @(negedge clk_i);
      check_irq(fast_intr_o, expected_fast(), "fast_intr_o after mask write");
      drive_ext(NEXT_INT'(random_bits(NEXT_INT)));
      apb_read(mcu_ctrl_pkg::IRQ_PENDING_OFS);
    end

    // gpio summary bit with empty and then full status
    apb_write(mcu_ctrl_pkg::IRQ_MASK_OFS, '1);
    apb_write(mcu_ctrl_pkg::GPIO_INTR_STATUS_OFS, '1);
    @(negedge clk_i);
    check_irq(fast_intr_o, expected_fast(), "fast_intr_o with empty status");
    apb_read(mcu_ctrl_pkg::IRQ_PENDING_OFS);
    drive_pins('0, 4);
    drive_pins('1, 4);
    @(negedge clk_i);
    check_irq(fast_intr_o, expected_fast(), "fast_intr_o with full status");
    apb_read(mcu_ctrl_pkg::IRQ_PENDING_OFS);

    // unmapped addresses and read-only registers
    apb_read(8'h0C);
    apb_read(8'h24);
    apb_read(8'h3C);
    apb_read(8'hFF);
    apb_write(8'h28, random_bits(32));
    apb_write(8'h01, random_bits(32));
    apb_write(mcu_ctrl_pkg::STRAPS_OFS, '1);
    apb_write(mcu_ctrl_pkg::GPIO_IN_OFS, '1);
    apb_write(mcu_ctrl_pkg::IRQ_PENDING_OFS, '1);
    for (int i = 0; i < 10; i++) begin
      apb_read(mapped_ofs[i]);
    end

    repeat (4) @(posedge clk_i);
    if (exp_data_q.size() != 0) begin
      abort_run("some transfers never received a response");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

// ==== src.f ====
+incdir+test
hw/mcu_ctrl_pkg.sv
hw/ctrl_bus_if.sv
hw/apb_decode.sv
hw/soc_ctrl_regs.sv
hw/gpio_bank.sv
hw/irq_collect.sv
hw/read_result.sv
hw/mcu_ctrl_top.sv
test/tb_mcu_ctrl.sv
